//--- gpio_params.svh
////////////////////////////////////////////////////////////////////////////
// Sizes and register offsets shared by the GPIO port.
// Included by both packages and by the modules that decode
// addresses or size the event FIFO.
////////////////////////////////////////////////////////////////////////////

`ifndef GPIO_PARAMS_SVH
`define GPIO_PARAMS_SVH

// Number of GPIO pins
`define GPIO_DW 8
// Event FIFO entries
`define GPIO_FIFO_DEPTH 8
// Address bits decoded by the register block
`define GPIO_AW 5

// Register map, byte offsets
`define GPIO_REG_OE     'h00
`define GPIO_REG_OUT    'h04
`define GPIO_REG_IN     'h08
`define GPIO_REG_EVT_EN 'h0C
// Count in low bits, overflow in bit 8
`define GPIO_REG_STATUS 'h10
// Read pops one event
`define GPIO_REG_EVENT  'h14

`endif

//--- gpio_bus_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Types for the AXI4-Lite side of the GPIO port.
// Referenced with scoped names, never imported.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "gpio_params.svh"

package gpio_bus_pkg;

  // Full bus address
  typedef logic [31:0] addr_t;

  // Bus data word
  typedef logic [31:0] data_t;

  // AXI response code
  typedef logic [1:0] resp_t;

  // Only response ever returned
  localparam resp_t resp_okay = 2'b00;

  // Low address bits actually decoded
  typedef logic [`GPIO_AW-1:0] reg_off_t;

endpackage

`default_nettype wire

//--- gpio_pin_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Types for the pin side of the GPIO port.
// Covers pin vectors, change events and FIFO fill count.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "gpio_params.svh"

package gpio_pin_pkg;

  // One bit per pin
  typedef logic [`GPIO_DW-1:0] pin_vec_t;

  // Change event
  // Upper half is the change mask
  // Lower half is the pin level after the change
  typedef logic [2*`GPIO_DW-1:0] event_t;

  // FIFO fill level, 0 up to depth inclusive
  typedef logic [$clog2(`GPIO_FIFO_DEPTH+1)-1:0] count_t;

endpackage

`default_nettype wire

//--- gpio_pin_sync.sv
////////////////////////////////////////////////////////////////////////////
// Input pin synchronizer and change detector.
// Brings the pins into the bus clock domain and raises evt_push
// in every cycle where an enabled pin changed level.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module gpio_pin_sync (
  input  logic                   bus,
  input  logic                   rst_n,
  // Raw pins from the connector
  input  gpio_pin_pkg::pin_vec_t pins,
  // Per pin change detect enable
  input  gpio_pin_pkg::pin_vec_t evt_en,
  // Synchronized pin level
  output gpio_pin_pkg::pin_vec_t level,
  // Change event strobe and payload
  output logic                   evt_push,
  output gpio_pin_pkg::event_t   evt_data
);

  // First synchronizer stage
  gpio_pin_pkg::pin_vec_t meta;
  // Level seen one cycle earlier
  gpio_pin_pkg::pin_vec_t prev;
  // Enabled pins that changed this cycle
  gpio_pin_pkg::pin_vec_t chg_mask;

  //////////////////////////////////////////////////////////////////////////
  // Synchronizer
  //////////////////////////////////////////////////////////////////////////

  // Two flops, level valid after the second edge
  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      meta  <= '0;
      level <= '0;
      prev  <= '0;
    end else begin
      meta  <= pins;
      level <= meta;
      // Third stage only for edge detection
      prev  <= level;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Change detect
  //////////////////////////////////////////////////////////////////////////

  // Disabled pins never contribute
  assign chg_mask = (level ^ prev) & evt_en;

  // Any enabled edge makes one event
  assign evt_push = |chg_mask;

  // Mask on top, current level below
  assign evt_data = {chg_mask, level};

endmodule

`default_nettype wire

//--- gpio_event_fifo.sv
////////////////////////////////////////////////////////////////////////////
// Show-ahead FIFO for pin change events.
// Head entry is visible without a pop and reads zero when empty.
// Pushes into a full FIFO are lost and set a sticky overflow flag.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "gpio_params.svh"

module gpio_event_fifo (
  input  logic                 bus,
  input  logic                 rst_n,
  input  logic                 push,
  input  gpio_pin_pkg::event_t push_data,
  input  logic                 pop,
  input  logic                 ovf_clr,
  output gpio_pin_pkg::event_t head_data,
  output gpio_pin_pkg::count_t count,
  output logic                 overflow
);

  localparam int unsigned DEPTH = `GPIO_FIFO_DEPTH;
  localparam int unsigned PW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  gpio_pin_pkg::event_t mem [DEPTH];

  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic          empty;
  logic          full;
  logic          do_push;
  logic          do_pop;

  // Pointer advance with wrap at depth
  function automatic logic [PW-1:0] ptr_next(input logic [PW-1:0] ptr);
    if (ptr == PW'(DEPTH-1)) return '0;
    return ptr + PW'(1);
  endfunction

  assign empty = (count == '0);
  assign full  = (count == gpio_pin_pkg::count_t'(DEPTH));

  // Pop on empty is ignored
  assign do_pop  = pop & ~empty;
  // Simultaneous pop frees a slot for the push
  assign do_push = push & (~full | do_pop);

  // Storage
  always_ff @(posedge bus) begin
    if (do_push) mem[wr_ptr] <= push_data;
  end

  // Pointers and fill count
  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= ptr_next(wr_ptr);
      if (do_pop)  rd_ptr <= ptr_next(rd_ptr);
      case ({do_push, do_pop})
        2'b10:   count <= count + gpio_pin_pkg::count_t'(1);
        2'b01:   count <= count - gpio_pin_pkg::count_t'(1);
        default: count <= count;
      endcase
    end
  end

  // Sticky overflow where a new drop wins over a clear
  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      overflow <= 1'b0;
    end else if (push & ~do_push) begin
      overflow <= 1'b1;
    end else if (ovf_clr) begin
      overflow <= 1'b0;
    end
  end

  // Show-ahead head
  assign head_data = empty ? '0 : mem[rd_ptr];

endmodule

`default_nettype wire

//--- gpio_regs.sv
////////////////////////////////////////////////////////////////////////////
// AXI4-Lite slave holding the GPIO register map.
// Writes need address and data valid together, reads return a
// registered data word. Reading EVENT pops the event FIFO.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "gpio_params.svh"

module gpio_regs (
  input  logic                   bus,
  input  logic                   rst_n,
  // Write address and data
  input  gpio_bus_pkg::addr_t    aw_addr,
  input  logic                   aw_valid,
  output logic                   aw_ready,
  input  gpio_bus_pkg::data_t    w_data,
  input  logic                   w_valid,
  output logic                   w_ready,
  // Write response
  output gpio_bus_pkg::resp_t    b_resp,
  output logic                   b_valid,
  input  logic                   b_ready,
  // Read address
  input  gpio_bus_pkg::addr_t    ar_addr,
  input  logic                   ar_valid,
  output logic                   ar_ready,
  // Read data
  output gpio_bus_pkg::data_t    r_data,
  output gpio_bus_pkg::resp_t    r_resp,
  output logic                   r_valid,
  input  logic                   r_ready,
  // Pin side status
  input  gpio_pin_pkg::pin_vec_t level,
  input  gpio_pin_pkg::event_t   head_data,
  input  gpio_pin_pkg::count_t   count,
  input  logic                   overflow,
  // Pin side control
  output gpio_pin_pkg::pin_vec_t gpio_e,
  output gpio_pin_pkg::pin_vec_t gpio_o,
  output gpio_pin_pkg::pin_vec_t evt_en,
  output logic                   evt_pop,
  output logic                   ovf_clr
);

  //////////////////////////////////////////////////////////////////////////
  // Write channel
  //////////////////////////////////////////////////////////////////////////

  gpio_bus_pkg::reg_off_t wr_off;
  logic                   wr_both;
  logic                   wr_acc;
  logic                   b_acc;

  assign wr_off = aw_addr[`GPIO_AW-1:0];

  // Address and data must arrive together
  assign wr_both = aw_valid & w_valid;

  // Stall while an unread response is pending
  assign aw_ready = wr_both & (~b_valid | b_ready);
  assign w_ready  = wr_both & (~b_valid | b_ready);

  // Both channels transfer on the same edge
  assign wr_acc = aw_valid & aw_ready & w_valid & w_ready;
  assign b_acc  = b_valid & b_ready;

  // Writable registers
  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      gpio_e <= '0;
      gpio_o <= '0;
      evt_en <= '0;
    end else if (wr_acc) begin
      case (wr_off)
        `GPIO_REG_OE:     gpio_e <= w_data[`GPIO_DW-1:0];
        `GPIO_REG_OUT:    gpio_o <= w_data[`GPIO_DW-1:0];
        `GPIO_REG_EVT_EN: evt_en <= w_data[`GPIO_DW-1:0];
        // IN, STATUS, EVENT and holes keep nothing here
        default: ;
      endcase
    end
  end

  // Any write to STATUS clears the overflow flag
  assign ovf_clr = wr_acc & (wr_off == `GPIO_REG_STATUS);

  // Always OKAY
  assign b_resp = gpio_bus_pkg::resp_okay;

  // Response follows the accepting edge by one cycle
  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      b_valid <= 1'b0;
    end else begin
      b_valid <= wr_acc | (b_valid & ~b_acc);
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Read channel
  //////////////////////////////////////////////////////////////////////////

  gpio_bus_pkg::reg_off_t rd_off;
  gpio_bus_pkg::data_t    status_word;
  logic                   rd_acc;
  logic                   r_acc;

  assign rd_off = ar_addr[`GPIO_AW-1:0];

  // New address only once the last word is gone
  assign ar_ready = ~r_valid | r_ready;

  assign rd_acc = ar_valid & ar_ready;
  assign r_acc  = r_valid & r_ready;

  // STATUS layout
  always_comb begin
    status_word = '0;
    status_word[$bits(gpio_pin_pkg::count_t)-1:0] = count;
    status_word[8] = overflow;
  end

  // Head is consumed on the accepting edge
  assign evt_pop = rd_acc & (rd_off == `GPIO_REG_EVENT);

  // Read data, loaded only on acceptance so it holds under back-pressure
  always_ff @(posedge bus) begin
    if (rd_acc) begin
      case (rd_off)
        `GPIO_REG_OE:     r_data <= gpio_bus_pkg::data_t'(gpio_e);
        `GPIO_REG_OUT:    r_data <= gpio_bus_pkg::data_t'(gpio_o);
        `GPIO_REG_IN:     r_data <= gpio_bus_pkg::data_t'(level);
        `GPIO_REG_EVT_EN: r_data <= gpio_bus_pkg::data_t'(evt_en);
        `GPIO_REG_STATUS: r_data <= status_word;
        `GPIO_REG_EVENT:  r_data <= gpio_bus_pkg::data_t'(head_data);
        // Unmapped offsets read as zero
        default:          r_data <= '0;
      endcase
    end
  end

  assign r_resp = gpio_bus_pkg::resp_okay;

  // Valid one cycle after acceptance, held until taken
  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      r_valid <= 1'b0;
    end else begin
      r_valid <= rd_acc | (r_valid & ~r_acc);
    end
  end

endmodule

`default_nettype wire

//--- gpio_top.sv
////////////////////////////////////////////////////////////////////////////
// GPIO port top level with an AXI4-Lite register interface.
// Connects the pin synchronizer, event FIFO and register block.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module gpio_top (
  input  logic                   bus,
  input  logic                   rst_n,
  // Expansion connector
  output gpio_pin_pkg::pin_vec_t gpio_e,
  output gpio_pin_pkg::pin_vec_t gpio_o,
  input  gpio_pin_pkg::pin_vec_t gpio_i,
  // AXI4-Lite write
  input  gpio_bus_pkg::addr_t    aw_addr,
  input  logic                   aw_valid,
  output logic                   aw_ready,
  input  gpio_bus_pkg::data_t    w_data,
  input  logic                   w_valid,
  output logic                   w_ready,
  output gpio_bus_pkg::resp_t    b_resp,
  output logic                   b_valid,
  input  logic                   b_ready,
  // AXI4-Lite read
  input  gpio_bus_pkg::addr_t    ar_addr,
  input  logic                   ar_valid,
  output logic                   ar_ready,
  output gpio_bus_pkg::data_t    r_data,
  output gpio_bus_pkg::resp_t    r_resp,
  output logic                   r_valid,
  input  logic                   r_ready
);

  // Synchronizer to registers and FIFO
  gpio_pin_pkg::pin_vec_t level;
  gpio_pin_pkg::pin_vec_t evt_en;
  logic                   evt_push;
  gpio_pin_pkg::event_t   evt_data;
  // FIFO and registers
  gpio_pin_pkg::event_t   head_data;
  gpio_pin_pkg::count_t   count;
  logic                   overflow;
  logic                   evt_pop;
  logic                   ovf_clr;

  gpio_pin_sync sync0 (
    .bus(bus), .rst_n(rst_n),
    .pins(gpio_i), .evt_en(evt_en),
    .level(level), .evt_push(evt_push), .evt_data(evt_data)
  );

  gpio_event_fifo fifo0 (
    .bus(bus), .rst_n(rst_n),
    .push(evt_push), .push_data(evt_data), .pop(evt_pop), .ovf_clr(ovf_clr),
    .head_data(head_data), .count(count), .overflow(overflow)
  );

  gpio_regs regs0 (
    .bus(bus), .rst_n(rst_n),
    .aw_addr(aw_addr), .aw_valid(aw_valid), .aw_ready(aw_ready),
    .w_data(w_data), .w_valid(w_valid), .w_ready(w_ready),
    .b_resp(b_resp), .b_valid(b_valid), .b_ready(b_ready),
    .ar_addr(ar_addr), .ar_valid(ar_valid), .ar_ready(ar_ready),
    .r_data(r_data), .r_resp(r_resp), .r_valid(r_valid), .r_ready(r_ready),
    .level(level), .head_data(head_data), .count(count), .overflow(overflow),
    .gpio_e(gpio_e), .gpio_o(gpio_o), .evt_en(evt_en),
    .evt_pop(evt_pop), .ovf_clr(ovf_clr)
  );

endmodule

`default_nettype wire

//--- tb_gpio_top.sv
////////////////////////////////////////////////////////////////////////////
// Directed testbench for the GPIO port top level.
// Drives the AXI4-Lite bus and the input pins, then checks register
// readback, pin outputs, change events and bus back-pressure.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "gpio_params.svh"

module tb_gpio_top;

  logic                   bus;
  logic                   rst_n;
  gpio_pin_pkg::pin_vec_t gpio_e, gpio_o, gpio_i;
  gpio_bus_pkg::addr_t    aw_addr, ar_addr;
  gpio_bus_pkg::data_t    w_data, r_data;
  gpio_bus_pkg::resp_t    b_resp, r_resp;
  logic                   aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
  logic                   ar_valid, ar_ready, r_valid, r_ready;

  // Running totals
  int checks;
  int errors;

  gpio_top dut0 (.*);

  // 40 ns bus clock
  initial begin
    bus = 1'b0;
    forever #20 bus = ~bus;
  end

  //////////////////////////////////////////////////////////////////////////
  // Compare and report
  //////////////////////////////////////////////////////////////////////////

  task automatic check_data(input string name, input gpio_bus_pkg::data_t got,
                            input gpio_bus_pkg::data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_resp(input string name, input gpio_bus_pkg::resp_t got,
                            input gpio_bus_pkg::resp_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_pins(input string name, input gpio_pin_pkg::pin_vec_t got,
                            input gpio_pin_pkg::pin_vec_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    $display("Timed out at %0t waiting for %s", $time, what);
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (errors == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - errs_before);
    end
  endtask

  //////////////////////////////////////////////////////////////////////////
  // Bus tasks
  //////////////////////////////////////////////////////////////////////////

  // Handshake signal by name
  function automatic logic sig_high(input string what);
    case (what)
      "aw_ready": return aw_ready & w_ready;
      "b_valid":  return b_valid;
      "ar_ready": return ar_ready;
      default:    return r_valid;
    endcase
  endfunction

  // Sampled on falling edges clear of the rising edge
  task automatic wait_high(input string what);
    int n;
    n = 0;
    @(negedge bus);
    while (!sig_high(what) && n < 100) begin
      @(negedge bus);
      n++;
    end
    if (!sig_high(what)) report_timeout(what);
  endtask

  // Starts and ends 2 ns after a rising edge
  task automatic axi_write(input gpio_bus_pkg::addr_t addr,
                           input gpio_bus_pkg::data_t data);
    aw_addr  = addr;
    w_data   = data;
    aw_valid = 1'b1;
    w_valid  = 1'b1;
    b_ready  = 1'b1;
    wait_high("aw_ready");
    @(posedge bus);
    #2;
    aw_valid = 1'b0;
    w_valid  = 1'b0;
    wait_high("b_valid");
    check_resp("b_resp", b_resp, gpio_bus_pkg::resp_okay);
    @(posedge bus);
    #2;
  endtask

  task automatic axi_read(input gpio_bus_pkg::addr_t addr,
                          output gpio_bus_pkg::data_t data);
    ar_addr  = addr;
    ar_valid = 1'b1;
    r_ready  = 1'b1;
    wait_high("ar_ready");
    @(posedge bus);
    #2;
    ar_valid = 1'b0;
    wait_high("r_valid");
    data = r_data;
    check_resp("r_resp", r_resp, gpio_bus_pkg::resp_okay);
    @(posedge bus);
    #2;
  endtask

  // Poll IN until the synchronized level follows the pins
  task automatic wait_in(input gpio_pin_pkg::pin_vec_t exp);
    gpio_bus_pkg::data_t d;
    int n;
    n = 0;
    axi_read(`GPIO_REG_IN, d);
    while (d !== gpio_bus_pkg::data_t'(exp) && n < 20) begin
      axi_read(`GPIO_REG_IN, d);
      n++;
    end
    check_data("IN", d, gpio_bus_pkg::data_t'(exp));
  endtask

  // Poll STATUS until the FIFO holds cnt events
  task automatic wait_event(input gpio_pin_pkg::count_t cnt);
    gpio_bus_pkg::data_t d;
    int n;
    n = 0;
    axi_read(`GPIO_REG_STATUS, d);
    while (gpio_pin_pkg::count_t'(d) != cnt && n < 20) begin
      axi_read(`GPIO_REG_STATUS, d);
      n++;
    end
    if (gpio_pin_pkg::count_t'(d) != cnt) report_timeout("event count in STATUS");
  endtask

  //////////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////////

  task automatic test_reset();
    gpio_bus_pkg::addr_t regs [5];
    gpio_bus_pkg::data_t d;
    regs = '{`GPIO_REG_OE, `GPIO_REG_OUT, `GPIO_REG_EVT_EN,
             `GPIO_REG_STATUS, `GPIO_REG_EVENT};
    check_pins("gpio_e", gpio_e, '0);
    check_pins("gpio_o", gpio_o, '0);
    foreach (regs[k]) begin
      axi_read(regs[k], d);
      check_data($sformatf("r_data at %h", regs[k]), d, '0);
    end
  endtask

  task automatic test_out_regs();
    gpio_pin_pkg::pin_vec_t v_oe, v_out;
    gpio_bus_pkg::data_t d;
    v_oe  = gpio_pin_pkg::pin_vec_t'($urandom);
    v_out = gpio_pin_pkg::pin_vec_t'($urandom);
    axi_write(`GPIO_REG_OE, gpio_bus_pkg::data_t'(v_oe));
    axi_write(`GPIO_REG_OUT, gpio_bus_pkg::data_t'(v_out));
    // Hole at 0x1C reads zero and keeps nothing
    axi_read(32'h1C, d);
    check_data("r_data at 1c", d, '0);
    axi_write(32'h1C, $urandom);
    axi_read(`GPIO_REG_OE, d);
    check_data("OE", d, gpio_bus_pkg::data_t'(v_oe));
    axi_read(`GPIO_REG_OUT, d);
    check_data("OUT", d, gpio_bus_pkg::data_t'(v_out));
    axi_read(`GPIO_REG_EVT_EN, d);
    check_data("EVT_EN", d, '0);
    check_pins("gpio_e", gpio_e, v_oe);
    check_pins("gpio_o", gpio_o, v_out);
  endtask

  task automatic test_events();
    gpio_pin_pkg::pin_vec_t mask, bit_i;
    gpio_bus_pkg::data_t d;
    mask = gpio_pin_pkg::pin_vec_t'($urandom);
    // Keep pin 0 enabled and the top pin disabled
    mask = mask | gpio_pin_pkg::pin_vec_t'(1);
    mask = mask & ~(gpio_pin_pkg::pin_vec_t'(1) << (`GPIO_DW - 1));
    axi_write(`GPIO_REG_EVT_EN, gpio_bus_pkg::data_t'(mask));
    for (int i = 0; i < `GPIO_DW; i++) begin
      bit_i  = gpio_pin_pkg::pin_vec_t'(1) << i;
      gpio_i = gpio_i ^ bit_i;
      wait_in(gpio_i);
      if ((mask & bit_i) != '0) begin
        wait_event(gpio_pin_pkg::count_t'(1));
        axi_read(`GPIO_REG_EVENT, d);
        check_data("EVENT", d, gpio_bus_pkg::data_t'({bit_i, gpio_i}));
      end else begin
        axi_read(`GPIO_REG_STATUS, d);
        check_data("STATUS", d, '0);
      end
    end
    axi_read(`GPIO_REG_EVENT, d);
    check_data("EVENT when empty", d, '0);
  endtask

  task automatic test_overflow();
    gpio_bus_pkg::data_t exp_evt [`GPIO_FIFO_DEPTH];
    gpio_bus_pkg::data_t d;
    gpio_pin_pkg::pin_vec_t bit_k;
    axi_write(`GPIO_REG_EVT_EN, gpio_bus_pkg::data_t'({`GPIO_DW{1'b1}}));
    // Ten changes where the last two find the FIFO full
    for (int k = 0; k < 10; k++) begin
      bit_k  = gpio_pin_pkg::pin_vec_t'(1) << (k % `GPIO_DW);
      gpio_i = gpio_i ^ bit_k;
      wait_in(gpio_i);
      if (k < `GPIO_FIFO_DEPTH) exp_evt[k] = gpio_bus_pkg::data_t'({bit_k, gpio_i});
    end
    wait_event(gpio_pin_pkg::count_t'(`GPIO_FIFO_DEPTH));
    axi_read(`GPIO_REG_STATUS, d);
    check_data("STATUS", d, gpio_bus_pkg::data_t'(`GPIO_FIFO_DEPTH) | 32'h100);
    foreach (exp_evt[k]) begin
      axi_read(`GPIO_REG_EVENT, d);
      check_data("EVENT", d, exp_evt[k]);
    end
    axi_read(`GPIO_REG_EVENT, d);
    check_data("EVENT when empty", d, '0);
    axi_write(`GPIO_REG_STATUS, $urandom);
    axi_read(`GPIO_REG_STATUS, d);
    check_data("STATUS", d, '0);
  endtask

  task automatic test_backpressure();
    gpio_pin_pkg::pin_vec_t v1;
    gpio_pin_pkg::pin_vec_t v1_inv;
    gpio_bus_pkg::data_t held;
    v1     = gpio_pin_pkg::pin_vec_t'($urandom);
    v1_inv = ~v1;
    axi_write(`GPIO_REG_OUT, gpio_bus_pkg::data_t'(v1));
    // Read of OUT left waiting with r_ready low
    r_ready  = 1'b0;
    ar_addr  = `GPIO_REG_OUT;
    ar_valid = 1'b1;
    wait_high("ar_ready");
    @(posedge bus);
    #2;
    ar_valid = 1'b0;
    wait_high("r_valid");
    held = r_data;
    check_data("r_data", held, gpio_bus_pkg::data_t'(v1));
    @(posedge bus);
    #2;
    // New OUT value must not leak into the held word
    axi_write(`GPIO_REG_OUT, gpio_bus_pkg::data_t'(v1_inv));
    // Second read offered while the first word is still held
    ar_addr  = `GPIO_REG_OUT;
    ar_valid = 1'b1;
    repeat (4) begin
      @(negedge bus);
      check_data("ar_ready", gpio_bus_pkg::data_t'(ar_ready), '0);
      check_data("r_valid", gpio_bus_pkg::data_t'(r_valid), 32'h1);
      check_data("r_data", r_data, held);
    end
    @(posedge bus);
    #2;
    r_ready = 1'b1;
    wait_high("ar_ready");
    @(posedge bus);
    #2;
    ar_valid = 1'b0;
    wait_high("r_valid");
    check_data("r_data", r_data, gpio_bus_pkg::data_t'(v1_inv));
    @(posedge bus);
    #2;
    check_data("r_valid", gpio_bus_pkg::data_t'(r_valid), '0);

    // Write response left waiting with b_ready low
    b_ready  = 1'b0;
    aw_addr  = `GPIO_REG_OE;
    w_data   = gpio_bus_pkg::data_t'(v1);
    aw_valid = 1'b1;
    w_valid  = 1'b1;
    wait_high("aw_ready");
    @(posedge bus);
    #2;
    // Second write offered at once
    w_data = gpio_bus_pkg::data_t'(v1_inv);
    repeat (4) begin
      @(negedge bus);
      check_data("aw_ready", gpio_bus_pkg::data_t'(aw_ready), '0);
      check_data("w_ready", gpio_bus_pkg::data_t'(w_ready), '0);
      check_data("b_valid", gpio_bus_pkg::data_t'(b_valid), 32'h1);
      check_pins("gpio_e", gpio_e, v1);
    end
    @(posedge bus);
    #2;
    b_ready = 1'b1;
    wait_high("aw_ready");
    @(posedge bus);
    #2;
    aw_valid = 1'b0;
    w_valid  = 1'b0;
    wait_high("b_valid");
    @(posedge bus);
    #2;
    check_pins("gpio_e", gpio_e, v1_inv);
  endtask

  //////////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////////

  initial begin
    int base;
    void'($urandom(32'h9534d9c0));
    checks   = 0;
    errors   = 0;
    rst_n    = 1'b0;
    gpio_i   = '0;
    aw_addr  = '0;
    aw_valid = 1'b0;
    w_data   = '0;
    w_valid  = 1'b0;
    b_ready  = 1'b1;
    ar_addr  = '0;
    ar_valid = 1'b0;
    r_ready  = 1'b1;
    repeat (5) @(posedge bus);
    #2;
    rst_n = 1'b1;

    base = errors;
    test_reset();
    report_test("reset values", base);
    base = errors;
    test_out_regs();
    report_test("output registers", base);
    base = errors;
    test_in_read();
    report_test("input readback", base);
    base = errors;
    test_events();
    report_test("event capture", base);
    base = errors;
    test_overflow();
    report_test("event overflow", base);
    base = errors;
    test_backpressure();
    report_test("back-pressure", base);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  task automatic test_in_read();
    gpio_i = gpio_pin_pkg::pin_vec_t'($urandom);
    wait_in(gpio_i);
  endtask

endmodule

`default_nettype wire

//--- gpio.f
+incdir+.
gpio_bus_pkg.sv
gpio_pin_pkg.sv
gpio_pin_sync.sv
gpio_event_fifo.sv
gpio_regs.sv
gpio_top.sv
tb_gpio_top.sv

//--- run.sh
#!/bin/sh
# Compile and run the GPIO testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f gpio.f --top-module tb_gpio_top -o tb_gpio_top

out=$(./obj_dir/tb_gpio_top)
echo "$out"

if echo "$out" | grep -qx "TESTS PASSED"; then
  echo "simulation passed"
  exit 0
fi

echo "simulation failed"
exit 1
